// ==== src/sv32_pkg.sv ====
// shared types and constants for the sv32 instruction fetch mmu.
// satp mode is always sv32; machine mode is the only bypass.
// no tlb, no mxr/sum, no dirty or accessed bit updates by hardware.
// physical addresses are 34 bits wide, as in the rv32 sv32 scheme.
package sv32_pkg;

  // default request queue depth, overridden from the top level.
  localparam int FIFO_DEPTH = 4;

  // privilege mode, rv32 encoding.
  // value 2 is reserved.
  typedef enum logic [1:0] {
    priv_user       = 2'd0,
    priv_supervisor = 2'd1,
    priv_machine    = 2'd3
  } priv_e;

  // pte flag bit positions.
  localparam int PTE_V = 0;
  localparam int PTE_R = 1;
  localparam int PTE_W = 2;
  localparam int PTE_X = 3;
  localparam int PTE_U = 4;
  localparam int PTE_A = 6;

  // pte physical page number fields.
  localparam int PTE_PPN0_LO = 10;
  localparam int PTE_PPN0_HI = 19;
  localparam int PTE_PPN1_LO = 20;
  localparam int PTE_PPN1_HI = 31;

  // sv32 geometry.
  localparam int SV32_PAGE_SHIFT = 12;
  localparam int SV32_PTE_SIZE   = 4;
  localparam int SV32_PPN_BITS   = 22;
  localparam int SV32_VPN_BITS   = 10;
  // vpn1 is vaddr[31:22], vpn0 is vaddr[21:12].
  localparam int SV32_VPN1_LSB   = 22;
  localparam int SV32_VPN0_LSB   = 12;

  // fetch request from the fetch stage.
  typedef struct packed {
    logic [31:0] vaddr;
    priv_e       priv;
  } fetch_req_t;

  // fetch response.
  // paddr is all ones on a fault.
  typedef struct packed {
    logic [33:0] paddr;
    logic        page_fault;
  } fetch_rsp_t;

  // walker answer: leaf pte and walk outcome.
  typedef struct packed {
    logic [31:0] pte;
    logic        superpage;
    logic        walk_fault;
  } walk_rsp_t;

endpackage

// ==== src/fetch_req_fifo.sv ====
// circular request queue between the fetch stage and the translation unit.
// in_ready drops only when full; a full queue still takes a write
// in a cycle where the head is popped.
// storage has no reset, only the pointers and the count do.
`timescale 1ns/1ps

module fetch_req_fifo
  import sv32_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       resetn,
  input  fetch_req_t in,
  input  logic       in_valid,
  output logic       in_ready,
  output fetch_req_t out,
  output logic       out_valid,
  input  logic       out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  fetch_req_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  // wrap at depth, so depth need not be a power of two.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full      = (count == CNT_W'(DEPTH));
  assign in_ready  = !full || out_ready;
  assign out_valid = (count != '0);
  assign out       = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      // count moves only when exactly one side transfers.
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // head slot is read before this write lands when full.
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in;
  end

endmodule

// ==== src/sv32_itranslate.sv ====
// instruction address translation unit, one request at a time.
// machine mode passes the address through, zero extended.
// supervisor and user modes ask the walker for the leaf pte and then
// apply the execute rules; mxr and sum are not supported.
// the response is held while rsp_ready is low and nothing is popped.
`timescale 1ns/1ps

module sv32_itranslate
  import sv32_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  fetch_req_t  q_req,
  input  logic        q_valid,
  output logic        q_ready,
  output logic [31:0] walk_vaddr,
  output logic        walk_valid,
  input  logic        walk_ready,
  input  walk_rsp_t   walk_rsp,
  input  logic        walk_rsp_valid,
  output fetch_rsp_t  rsp,
  output logic        rsp_valid,
  input  logic        rsp_ready
);

  // idle, walk request, wait for walk answer, respond.
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_walk = 2'd1;
  localparam logic [1:0] st_wait = 2'd2;
  localparam logic [1:0] st_resp = 2'd3;

  logic [1:0]  state;
  fetch_req_t  cur;
  fetch_rsp_t  rsp_q;
  logic [31:0] pte;
  logic        perm_fault;
  logic [33:0] leaf_paddr;

  assign pte = walk_rsp.pte;

  // execute permission check on the leaf.
  always_comb begin
    perm_fault = walk_rsp.walk_fault;
    // reserved write without read.
    if (pte[PTE_W] && !pte[PTE_R]) perm_fault = 1'b1;
    // accessed bit must already be set.
    if (!pte[PTE_A]) perm_fault = 1'b1;
    case (cur.priv)
      priv_supervisor: begin
        // no execution of user pages from supervisor.
        if (pte[PTE_U] || !pte[PTE_X]) perm_fault = 1'b1;
      end
      priv_user: begin
        if (!(pte[PTE_X] && pte[PTE_U])) perm_fault = 1'b1;
      end
      // reserved encoding never translates.
      default: perm_fault = 1'b1;
    endcase
  end

  // superpage keeps vpn0 from the virtual address.
  always_comb begin
    if (walk_rsp.superpage) begin
      leaf_paddr = {pte[PTE_PPN1_HI:PTE_PPN1_LO],
                    cur.vaddr[SV32_VPN0_LSB +: SV32_VPN_BITS],
                    cur.vaddr[SV32_PAGE_SHIFT-1:0]};
    end else begin
      leaf_paddr = {pte[PTE_PPN1_HI:PTE_PPN0_LO], cur.vaddr[SV32_PAGE_SHIFT-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (q_valid) state <= (q_req.priv == priv_machine) ? st_resp : st_walk;
        end
        st_walk: if (walk_ready) state <= st_wait;
        st_wait: if (walk_rsp_valid) state <= st_resp;
        st_resp: if (rsp_ready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // payload registers.
  always_ff @(posedge clk) begin
    if (q_valid && q_ready) begin
      cur <= q_req;
      // bypass result, overwritten later for a walked request.
      rsp_q.paddr      <= {2'b00, q_req.vaddr};
      rsp_q.page_fault <= 1'b0;
    end else if (state == st_wait && walk_rsp_valid) begin
      rsp_q.paddr      <= perm_fault ? '1 : leaf_paddr;
      rsp_q.page_fault <= perm_fault;
    end
  end

  assign q_ready    = (state == st_idle);
  assign walk_valid = (state == st_walk);
  assign walk_vaddr = cur.vaddr;
  assign rsp_valid  = (state == st_resp);
  assign rsp        = rsp_q;

endmodule

// ==== src/sv32_page_walker.sv ====
// two level sv32 page table walker with one read outstanding.
// satp_ppn must stay stable for the whole walk.
// the read answer has no back pressure and is always taken.
// accessed and dirty bits are never written back.
// walk_rsp_valid is a single cycle pulse.
`timescale 1ns/1ps

module sv32_page_walker
  import sv32_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetn,
  input  logic [SV32_PPN_BITS-1:0] satp_ppn,
  input  logic [31:0]              walk_vaddr,
  input  logic                     walk_valid,
  output logic                     walk_ready,
  output walk_rsp_t                walk_rsp,
  output logic                     walk_rsp_valid,
  output logic [33:0]              mem_addr,
  output logic                     mem_valid,
  input  logic                     mem_ready,
  input  logic [31:0]              mem_rdata,
  input  logic                     mem_rvalid
);

  typedef enum logic [2:0] {
    idle,
    req_l1,
    wait_l1,
    req_l0,
    wait_l0,
    done
  } walk_state_e;

  walk_state_e              state;
  logic [31:0]              vaddr_q;
  logic [SV32_PPN_BITS-1:0] next_ppn_q;
  walk_rsp_t                rsp_q;

  logic                     pte_bad;
  logic                     pte_leaf;
  logic                     ppn0_set;
  logic [SV32_PPN_BITS-1:0] table_ppn;
  logic [SV32_VPN_BITS-1:0] vpn;

  // decode of the word coming back from memory.
  // invalid, or the reserved write without read.
  assign pte_bad  = !mem_rdata[PTE_V] || (mem_rdata[PTE_W] && !mem_rdata[PTE_R]);
  assign pte_leaf = mem_rdata[PTE_R] || mem_rdata[PTE_X];
  // superpage alignment needs ppn0 zero.
  assign ppn0_set = (mem_rdata[PTE_PPN0_HI:PTE_PPN0_LO] != '0);

  // table base and index per level.
  assign table_ppn = (state == req_l0) ? next_ppn_q : satp_ppn;
  assign vpn = (state == req_l0) ? vaddr_q[SV32_VPN0_LSB +: SV32_VPN_BITS]
                                 : vaddr_q[SV32_VPN1_LSB +: SV32_VPN_BITS];

  assign mem_addr = {table_ppn, {SV32_PAGE_SHIFT{1'b0}}} + 34'(vpn) * 34'(SV32_PTE_SIZE);
  assign mem_valid = (state == req_l1) || (state == req_l0);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= idle;
    end else begin
      case (state)
        idle: if (walk_valid) state <= req_l1;
        req_l1: if (mem_ready) state <= wait_l1;
        wait_l1: begin
          if (mem_rvalid) begin
            // a pointer entry continues to level 0.
            state <= (pte_bad || pte_leaf) ? done : req_l0;
          end
        end
        req_l0: if (mem_ready) state <= wait_l0;
        wait_l0: if (mem_rvalid) state <= done;
        done: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // walk payload.
  always_ff @(posedge clk) begin
    if (state == idle && walk_valid) begin
      vaddr_q <= walk_vaddr;
    end
    if (state == wait_l1 && mem_rvalid) begin
      rsp_q.pte        <= mem_rdata;
      rsp_q.superpage  <= pte_leaf;
      rsp_q.walk_fault <= pte_bad || (pte_leaf && ppn0_set);
      next_ppn_q       <= mem_rdata[PTE_PPN1_HI:PTE_PPN0_LO];
    end
    if (state == wait_l0 && mem_rvalid) begin
      rsp_q.pte        <= mem_rdata;
      rsp_q.superpage  <= 1'b0;
      // level 0 must end in a leaf.
      rsp_q.walk_fault <= pte_bad || !pte_leaf;
    end
  end

  assign walk_ready     = (state == idle);
  assign walk_rsp_valid = (state == done);
  assign walk_rsp       = rsp_q;

endmodule

// ==== src/sv32_fetch_mmu.sv ====
// sv32 instruction fetch mmu top: queue, translation unit, walker.
// responses leave in request order.
// satp_ppn must not change while requests are outstanding.
`timescale 1ns/1ps

module sv32_fetch_mmu
  import sv32_pkg::*;
#(
  parameter int FIFO_DEPTH = sv32_pkg::FIFO_DEPTH
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic [SV32_PPN_BITS-1:0] satp_ppn,
  input  fetch_req_t               req,
  input  logic                     req_valid,
  output logic                     req_ready,
  output fetch_rsp_t               rsp,
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output logic [33:0]              mem_addr,
  output logic                     mem_valid,
  input  logic                     mem_ready,
  input  logic [31:0]              mem_rdata,
  input  logic                     mem_rvalid
);

  // queue to translation unit.
  fetch_req_t  q_req;
  logic        q_valid;
  logic        q_ready;
  // translation unit to walker and back.
  logic [31:0] walk_vaddr;
  logic        walk_valid;
  logic        walk_ready;
  walk_rsp_t   walk_rsp;
  logic        walk_rsp_valid;

  fetch_req_fifo #(
    .DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .resetn   (resetn),
    .in       (req),
    .in_valid (req_valid),
    .in_ready (req_ready),
    .out      (q_req),
    .out_valid(q_valid),
    .out_ready(q_ready)
  );

  sv32_itranslate u_itranslate (
    .clk           (clk),
    .resetn        (resetn),
    .q_req         (q_req),
    .q_valid       (q_valid),
    .q_ready       (q_ready),
    .walk_vaddr    (walk_vaddr),
    .walk_valid    (walk_valid),
    .walk_ready    (walk_ready),
    .walk_rsp      (walk_rsp),
    .walk_rsp_valid(walk_rsp_valid),
    .rsp           (rsp),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready)
  );

  sv32_page_walker u_walker (
    .clk           (clk),
    .resetn        (resetn),
    .satp_ppn      (satp_ppn),
    .walk_vaddr    (walk_vaddr),
    .walk_valid    (walk_valid),
    .walk_ready    (walk_ready),
    .walk_rsp      (walk_rsp),
    .walk_rsp_valid(walk_rsp_valid),
    .mem_addr      (mem_addr),
    .mem_valid     (mem_valid),
    .mem_ready     (mem_ready),
    .mem_rdata     (mem_rdata),
    .mem_rvalid    (mem_rvalid)
  );

endmodule

// ==== tb/sv32_fetch_checker.sv ====
// in order response checker for the sv32 fetch mmu.
// expected results are queued before traffic starts.
// memory read transfers are counted against the expected total
// and must stay word aligned inside the 16 KiB page table memory.
`timescale 1ns/1ps

module sv32_fetch_checker
  import sv32_pkg::*;
(
  input logic        clk,
  input logic        resetn,
  input fetch_rsp_t  rsp,
  input logic        rsp_valid,
  input logic        rsp_ready,
  input logic [33:0] mem_addr,
  input logic        mem_valid,
  input logic        mem_ready
);

  logic [33:0] exp_paddr_q [$];
  logic        exp_fault_q [$];
  int          exp_reads = 0;
  int          mem_reads = 0;
  int          rsp_count = 0;
  int          mismatch_count = 0;
  int          missing_count = 0;
  int          extra_count = 0;

  task automatic push_expected(input logic [33:0] paddr, input logic fault, input int reads);
    exp_paddr_q.push_back(paddr);
    exp_fault_q.push_back(fault);
    exp_reads = exp_reads + reads;
  endtask

  // both sides are settled mid cycle.
  always @(negedge clk) begin
    logic [33:0] exp_paddr;
    logic        exp_fault;
    if (resetn && mem_valid && mem_ready) begin
      mem_reads = mem_reads + 1;
      // page tables live in byte addresses 0 to 0x3fff.
      if (mem_addr[33:14] != '0 || mem_addr[1:0] != '0) begin
        mismatch_count = mismatch_count + 1;
        $display("read at %0t from %h is outside the page table memory or misaligned",
                 $time, mem_addr);
      end
    end
    if (resetn && rsp_valid && rsp_ready) begin
      rsp_count = rsp_count + 1;
      if (exp_paddr_q.size() == 0) begin
        extra_count = extra_count + 1;
        $display("response %0d at %0t arrived with no request waiting for it",
                 rsp_count, $time);
      end else begin
        exp_paddr = exp_paddr_q.pop_front();
        exp_fault = exp_fault_q.pop_front();
        if (rsp.paddr !== exp_paddr) begin
          mismatch_count = mismatch_count + 1;
          $display("[ERROR] %0t rsp.paddr expected %h actual %h", $time, exp_paddr, rsp.paddr);
        end
        if (rsp.page_fault !== exp_fault) begin
          mismatch_count = mismatch_count + 1;
          $display("[ERROR] %0t rsp.page_fault expected %b actual %b",
                   $time, exp_fault, rsp.page_fault);
        end
      end
    end
  end

  // end of run accounting.
  task automatic close_out();
    missing_count = exp_paddr_q.size();
    if (missing_count != 0) $display("%0d expected responses never arrived", missing_count);
    if (mem_reads != exp_reads) begin
      mismatch_count = mismatch_count + 1;
      $display("[ERROR] %0t mem reads expected %0d actual %0d", $time, exp_reads, mem_reads);
    end
  endtask

endmodule

// ==== tb/sv32_fetch_assert.sv ====
// handshake assertions, bound into the mmu top.
// checked on rising edges, outside reset except for the reset check.
`timescale 1ns/1ps

module sv32_fetch_assert
  import sv32_pkg::*;
(
  input logic        clk,
  input logic        resetn,
  input fetch_rsp_t  rsp,
  input logic        rsp_valid,
  input logic        rsp_ready,
  input logic [33:0] mem_addr,
  input logic        mem_valid,
  input logic        mem_ready,
  input logic        mem_rvalid,
  input logic [31:0] walk_vaddr,
  input logic        walk_valid,
  input logic        walk_ready
);

  int   fail_count = 0;
  logic rd_open;

  // open from the read transfer to its answer.
  always_ff @(posedge clk) begin
    if (!resetn) rd_open <= 1'b0;
    else if (mem_valid && mem_ready) rd_open <= 1'b1;
    else if (mem_rvalid) rd_open <= 1'b0;
  end

  rsp_hold: assert property (@(posedge clk) disable iff (!resetn)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
      fail_count++;
      $error("rsp_valid dropped or rsp changed before rsp_ready");
    end

  mem_hold: assert property (@(posedge clk) disable iff (!resetn)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr))
    else begin
      fail_count++;
      $error("mem_valid dropped or mem_addr changed before mem_ready");
    end

  walk_hold: assert property (@(posedge clk) disable iff (!resetn)
    walk_valid && !walk_ready |=> walk_valid && $stable(walk_vaddr))
    else begin
      fail_count++;
      $error("walk_valid dropped or walk_vaddr changed before walk_ready");
    end

  reset_idle: assert property (@(posedge clk)
    !resetn |=> !rsp_valid && !mem_valid && !walk_valid)
    else begin
      fail_count++;
      $error("a valid is high right after reset");
    end

  // one read outstanding at a time.
  single_read: assert property (@(posedge clk) disable iff (!resetn)
    rd_open |-> !mem_valid)
    else begin
      fail_count++;
      $error("mem_valid raised while a read is outstanding");
    end

endmodule

bind sv32_fetch_mmu sv32_fetch_assert u_assert (.*);

// ==== tb/tb_sv32_fetch_mmu.sv ====
// testbench for the sv32 instruction fetch mmu.
// page tables, requests and expected results come from tb/stim_fetch.txt.
// the memory model holds 4096 words, byte addresses 0 to 0x3fff.
// gaps, stalls and read delays come from a fixed seed lcg.
`timescale 1ns/1ps

module tb_sv32_fetch_mmu
  import sv32_pkg::*;
();

  localparam int MEM_WORDS = 4096;

  logic                     clk;
  logic                     resetn;
  logic [SV32_PPN_BITS-1:0] satp_ppn;
  fetch_req_t               req;
  logic                     req_valid;
  logic                     req_ready;
  fetch_rsp_t               rsp;
  logic                     rsp_valid;
  logic                     rsp_ready;
  logic [33:0]              mem_addr;
  logic                     mem_valid;
  logic                     mem_ready;
  logic [31:0]              mem_rdata;
  logic                     mem_rvalid;

  // page table image, indexed by word address.
  logic [31:0] pt_mem [MEM_WORDS];
  logic [31:0] lcg_state = 32'ha8681826;
  logic [31:0] req_vaddr_q [$];
  logic [1:0]  req_priv_q [$];
  bit          req_burst_q [$];
  int          n_req = 0;
  int          timeout_limit = 0;
  int          cycle_count = 0;
  // read port bookkeeping of the memory model.
  logic        rd_taken = 1'b0;
  logic [11:0] rd_index;
  logic [11:0] rd_addr;
  int          rd_wait = 0;

  sv32_fetch_mmu #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) UUT (
    .clk       (clk),
    .resetn    (resetn),
    .satp_ppn  (satp_ppn),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .mem_addr  (mem_addr),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .mem_rvalid(mem_rvalid)
  );

  sv32_fetch_checker u_checker (
    .clk      (clk),
    .resetn   (resetn),
    .rsp      (rsp),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .mem_addr (mem_addr),
    .mem_valid(mem_valid),
    .mem_ready(mem_ready)
  );

  // numerical recipes lcg step.
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // s = satp, m = memory word, b = burst start, r = request.
  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    string       tag;
    logic [33:0] f1;
    logic [33:0] f2;
    logic [33:0] f3;
    logic [33:0] f4;
    logic [33:0] f5;
    bit          burst;
    burst = 1'b0;
    fd = $fopen("tb/stim_fetch.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/stim_fetch.txt, no stimulus loaded");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      tag = "";
      n = $fgets(line, fd);
      if (n == 0) break;
      n = $sscanf(line, "%s %h %h %h %h %h", tag, f1, f2, f3, f4, f5);
      if (tag == "s") begin
        satp_ppn = f1[SV32_PPN_BITS-1:0];
      end else if (tag == "m") begin
        pt_mem[f1[11:0]] = f2[31:0];
      end else if (tag == "b") begin
        burst = 1'b1;
      end else if (tag == "r" && n == 6) begin
        req_vaddr_q.push_back(f1[31:0]);
        req_priv_q.push_back(f2[1:0]);
        req_burst_q.push_back(burst);
        u_checker.push_expected(f3, f4[0], int'(f5));
      end
    end
    $fclose(fd);
  endtask

  // hold the request until the queue takes it.
  task automatic send_request(input logic [31:0] vaddr, input logic [1:0] priv);
    logic taken;
    req.vaddr = vaddr;
    req.priv  = priv_e'(priv);
    req_valid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = req_ready;
      @(posedge clk);
      #1;
    end
    req_valid = 1'b0;
  endtask

  task automatic finish_run(input bit timed_out);
    int failures;
    u_checker.close_out();
    failures = u_checker.mismatch_count + u_checker.missing_count +
               u_checker.extra_count + UUT.u_assert.fail_count;
    if (n_req == 0) $display("no requests were loaded from the stimulus file");
    $display("mismatches %0d, missing %0d, extra %0d, assertion failures %0d, timeouts %0d",
             u_checker.mismatch_count, u_checker.missing_count, u_checker.extra_count,
             UUT.u_assert.fail_count, timed_out);
    if (timed_out || failures != 0 || n_req == 0) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    resetn     = 1'b0;
    satp_ppn   = '0;
    req        = '0;
    req_valid  = 1'b0;
    rsp_ready  = 1'b0;
    mem_ready  = 1'b0;
    mem_rdata  = '0;
    mem_rvalid = 1'b0;
    // unused words read back as invalid ptes.
    for (int i = 0; i < MEM_WORDS; i++) pt_mem[i] = 32'hd000_0000 | (i << 12);
    load_stim();
    n_req = req_vaddr_q.size();
    timeout_limit = n_req * 40 + 200;
    repeat (2) @(posedge clk);
    #1;
    resetn = 1'b1;
    for (int i = 0; i < n_req; i++) begin
      // no gap inside the burst.
      if (!req_burst_q[i]) begin
        repeat (next_random() >> 30) begin
          @(posedge clk);
          #1;
        end
      end
      send_request(req_vaddr_q[i], req_priv_q[i]);
    end
    wait (u_checker.rsp_count >= n_req);
    // a few idle cycles to catch stray responses.
    repeat (10) @(posedge clk);
    finish_run(1'b0);
  end

  // capture a read transfer mid cycle.
  always @(negedge clk) begin
    rd_taken = resetn && mem_valid && mem_ready;
    rd_index = mem_addr[13:2];
  end

  // stalls and the delayed read answer.
  always @(posedge clk) begin
    #1;
    rsp_ready  = (next_random() >> 30) != 0;
    mem_ready  = (next_random() >> 30) != 0;
    mem_rvalid = 1'b0;
    if (rd_wait > 0) begin
      rd_wait = rd_wait - 1;
      if (rd_wait == 0) begin
        mem_rvalid = 1'b1;
        mem_rdata  = pt_mem[rd_addr];
      end
    end
    if (rd_taken) begin
      rd_wait = 1 + int'((next_random() >> 30) % 3);
      rd_addr = rd_index;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("timeout after %0d cycles, %0d responses still outstanding",
               cycle_count, n_req - u_checker.rsp_count);
      finish_run(1'b1);
    end
  end

endmodule

// ==== tb/stim_fetch.txt ====
# s satp_ppn | m word_address pte (word address is byte address / 4) | b starts a burst
# r vaddr priv expected_paddr expected_fault expected_mem_reads; hex, priv 0=u 1=s 3=m
s 000001
m 400 00000801
m 401 1230004b
m 402 0450044b
m 403 1230004a
m 404 3ff0005b
m 800 0eaf344b
m 801 c48d145b
m 802 00044443
m 803 0008884d
m 804 000ccc0b
m 805 000ff04a
m 806 00000c01
m 807 00111053
r deadbeef 3 0deadbeef 0 0
r 00000123 1 03abcd123 0 2
r 00001ffc 0 312345ffc 0 2
r 005550ab 1 048d550ab 0 1
b
r 00001000 1 3ffffffff 1 2
r 00002010 1 3ffffffff 1 2
r 00007000 0 3ffffffff 1 2
r 00000040 0 3ffffffff 1 2
r 00003000 1 3ffffffff 1 2
r 00004004 1 3ffffffff 1 2
r ffffffff 3 0ffffffff 0 0
r 00c00000 1 3ffffffff 1 1
r 00005000 1 3ffffffff 1 2
r 00801234 1 3ffffffff 1 1
r 00006000 0 3ffffffff 1 2
r 013ff800 0 0fffff800 0 1
r 01000000 1 3ffffffff 1 1

// ==== sim.f ====
src/sv32_pkg.sv
src/fetch_req_fifo.sv
src/sv32_itranslate.sv
src/sv32_page_walker.sv
src/sv32_fetch_mmu.sv
tb/sv32_fetch_checker.sv
tb/sv32_fetch_assert.sv
tb/tb_sv32_fetch_mmu.sv

// ==== Bender.yml ====
package:
  name: sv32_fetch_mmu

sources:
  # design, in compile order
  - src/sv32_pkg.sv
  - src/fetch_req_fifo.sv
  - src/sv32_itranslate.sv
  - src/sv32_page_walker.sv
  - src/sv32_fetch_mmu.sv
  # testbench
  - target: test
    files:
      - tb/sv32_fetch_checker.sv
      - tb/sv32_fetch_assert.sv
      - tb/tb_sv32_fetch_mmu.sv
